// File: hw/branchCond.sv
module branchCond
   import mcpPkg::*;
(
   input  logic [DalWidth-1:0] dal,         // Instruction word
   input  logic [PswWidth-1:0] psw,
   output logic                taken
);

   logic [4:0] code;                        // {dal[15], dal[11:8]}
   logic       cond;
   logic       nxorv;                       // Signed less than

   assign code  = {dal[DalWidth-1], dal[11:8]};
   assign nxorv = psw[FlagN] ^ psw[FlagV];

   always_comb
   begin
      case (code[4:1])
         BrCarry:
         begin
            cond = psw[FlagC];
         end
         BrOverflow:
         begin
            cond = psw[FlagV];
         end
         BrHigher:
         begin
            cond = psw[FlagZ] | psw[FlagC];
         end
         BrPlus:
         begin
            cond = psw[FlagN];
         end
         BrGreater:
         begin
            cond = psw[FlagZ] | nxorv;
         end
         BrGreaterEq:
         begin
            cond = nxorv;
         end
         BrEqual:
         begin
            cond = psw[FlagZ];
         end
         BrAlways:
         begin
            cond = 1'b1;
         end
         default:
         begin
            cond = 1'b0;                    // Not a branch
         end
      endcase
   end

   // Low code bit selects the sense of the pair
   assign taken = cond ^ ~code[0];

endmodule

// File: hw/mcpDecode.sv
module mcpDecode
   import mcpPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       inValid,
   input  decodeReq_t req,
   output logic       outValid,
   output decodeRsp_t rsp
);

   mirHigh_t            mirHigh;
   logic                jumpHit;
   logic                branchHit;
   logic [DmiWidth-1:0] dmiLines;
   decodeRsp_t          rspNext;            // Combined matrix results

   // Only the opcode byte reaches the matrices
   assign mirHigh = req.mir[MirWidth-1 -: MirHighWidth];

   microJump uJump
   (
      .mirHigh (mirHigh),
      .psw     (req.psw),
      .icc     (req.icc),
      .inpl    (req.inpl),
      .jump    (jumpHit)
   );

   microClass uClass
   (
      .mirHigh (mirHigh),
      .inpl    (req.inpl),
      .dmi     (dmiLines)
   );

   branchCond uBranch
   (
      .dal     (req.dal),
      .psw     (req.psw),
      .taken   (branchHit)
   );

   always_comb
   begin
      rspNext             = '0;
      rspNext.microJump   = jumpHit;
      rspNext.branchTaken = branchHit;
      rspNext.dmi         = dmiLines;
   end

   // One cycle latency, a new item every cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         outValid <= 1'b0;
         rsp      <= '0;
      end
      else
      begin
         outValid <= inValid;
         rsp      <= rspNext;                // Loaded every cycle, qualified by outValid
      end
   end

endmodule

// File: hw/mcpPkg.sv
package mcpPkg;

   localparam int MirWidth     = 16;        // Microinstruction word
   localparam int MirHighWidth = 8;         // Opcode byte of the microinstruction
   localparam int PswWidth     = 8;         // ALU and status flags
   localparam int DalWidth     = 16;        // PDP-11 instruction word
   localparam int DmiWidth     = 11;        // Number of class lines

   // Upper nibble of a conditional jump opcode, 0x10 to 0x1F
   localparam logic [3:0] JumpClass = 4'h1;

   // PSW bit positions, "NB ZB C4 C8 N Z V C"
   localparam int FlagC  = 0;
   localparam int FlagV  = 1;
   localparam int FlagZ  = 2;
   localparam int FlagN  = 3;
   localparam int FlagC8 = 4;
   localparam int FlagZB = 6;
   localparam int FlagNB = 7;

   // Condition select field of a jump opcode
   localparam logic [2:0] CondZB  = 3'd0;
   localparam logic [2:0] CondC8  = 3'd1;
   localparam logic [2:0] CondIcc = 3'd2;
   localparam logic [2:0] CondNB  = 3'd3;
   localparam logic [2:0] CondZ   = 3'd4;
   localparam logic [2:0] CondC   = 3'd5;
   localparam logic [2:0] CondV   = 3'd6;
   localparam logic [2:0] CondN   = 3'd7;

   // Class line positions on dmi
   localparam int DmiCawi   = 0;
   localparam int DmiCmb    = 1;            // cmb/cmw/cab/caw
   localparam int DmiSrbc   = 2;            // srbc/swrc
   localparam int DmiCad    = 3;
   localparam int DmiNop    = 4;
   localparam int DmiIo     = 5;
   localparam int DmiOutput = 6;
   localparam int DmiIw     = 7;
   localparam int DmiMi     = 8;
   localparam int DmiLgl    = 9;
   localparam int DmiMbMw   = 10;

   // Lines suppressed while the input latch is enabled
   localparam logic [DmiWidth-1:0] DmiInplMask = (DmiWidth'(1) << DmiSrbc)
                                               | (DmiWidth'(1) << DmiIo)
                                               | (DmiWidth'(1) << DmiOutput)
                                               | (DmiWidth'(1) << DmiIw)
                                               | (DmiWidth'(1) << DmiMi)
                                               | (DmiWidth'(1) << DmiLgl);

   // Branch code prefix {dal[15], dal[11:9]}
   localparam logic [3:0] BrCarry     = 4'b1011;   // bcc/bcs
   localparam logic [3:0] BrOverflow  = 4'b1010;   // bvc/bvs
   localparam logic [3:0] BrHigher    = 4'b1001;   // bhi/blos
   localparam logic [3:0] BrPlus      = 4'b1000;   // bpl/bmi
   localparam logic [3:0] BrGreater   = 4'b0011;   // bgt/ble
   localparam logic [3:0] BrGreaterEq = 4'b0010;   // bge/blt
   localparam logic [3:0] BrEqual     = 4'b0001;   // bne/beq
   localparam logic [3:0] BrAlways    = 4'b0000;   // br

   typedef struct packed {
      logic [3:0] opClass;                  // JumpClass for conditional jumps
      logic [2:0] condSel;                  // Flag to test
      logic       sense;                    // Flag value that takes the jump
   } jumpOp_t;

   // Opcode byte, seen either raw by the class decoder or split for jumps
   typedef union packed {
      logic [MirHighWidth-1:0] raw;
      jumpOp_t                 jump;
   } mirHigh_t;

   typedef struct packed {
      logic [MirWidth-1:0] mir;
      logic [PswWidth-1:0] psw;
      logic                icc;             // Indirect condition code
      logic                inpl;            // Input latch enable
      logic [DalWidth-1:0] dal;
   } decodeReq_t;

   typedef struct packed {
      logic                microJump;
      logic                branchTaken;
      logic [DmiWidth-1:0] dmi;
   } decodeRsp_t;

endpackage

// File: hw/microClass.sv
module microClass
   import mcpPkg::*;
(
   input  mirHigh_t            mirHigh,     // Opcode byte
   input  logic                inpl,
   output logic [DmiWidth-1:0] dmi
);

   logic [MirHighWidth-1:0] op;
   logic [DmiWidth-1:0]     pl;             // Raw pattern hits
   logic [DmiWidth-1:0]     inplKill;

   assign op = mirHigh.raw;

   // Wildcard compare, ? bits are don't care
   always_comb
   begin
      pl = '0;
      pl[DmiCawi]   = (op ==? 8'b1010111?);
      pl[DmiCmb]    = (op ==? 8'b10?001??);  // cmb/cmw/cab/caw
      pl[DmiSrbc]   = (op ==? 8'b110110??);  // srbc/swrc
      pl[DmiCad]    = (op ==? 8'b10101100);
      pl[DmiNop]    = (op ==? 8'b11111111);
      pl[DmiIo]     = (op ==? 8'b1111????);  // Whole I/O group
      pl[DmiOutput] = (op ==? 8'b?11111??);
      pl[DmiIw]     = (op ==? 8'b1110001?);
      pl[DmiMi]     = (op ==? 8'b111011??);
      pl[DmiLgl]    = (op ==? 8'b01110101);
      pl[DmiMbMw]   = (op ==? 8'b10??????);  // Overlaps cawi, cad and cmb
   end

   // Overlapping lines are intentional, several can be high at once
   assign inplKill = {DmiWidth{inpl}} & DmiInplMask;

   assign dmi = pl & ~inplKill;

endmodule

// File: hw/microJump.sv
module microJump
   import mcpPkg::*;
(
   input  mirHigh_t            mirHigh,     // Opcode byte
   input  logic [PswWidth-1:0] psw,
   input  logic                icc,
   input  logic                inpl,
   output logic                jump
);

   jumpOp_t op;
   logic    flagSel;                        // Flag picked by condSel
   logic    isJump;

   assign op = mirHigh.jump;

   // Flag order follows the opcode pairs 0x10/0x11 through 0x1E/0x1F
   always_comb
   begin
      case (op.condSel)
         CondZB:
         begin
            flagSel = psw[FlagZB];
         end
         CondC8:
         begin
            flagSel = psw[FlagC8];
         end
         CondIcc:
         begin
            flagSel = icc;                  // Not part of the PSW
         end
         CondNB:
         begin
            flagSel = psw[FlagNB];
         end
         CondZ:
         begin
            flagSel = psw[FlagZ];
         end
         CondC:
         begin
            flagSel = psw[FlagC];
         end
         CondV:
         begin
            flagSel = psw[FlagV];
         end
         default:
         begin
            flagSel = psw[FlagN];           // CondN
         end
      endcase
   end

   assign isJump = (op.opClass == JumpClass);

   // Even opcodes jump on a clear flag, odd ones on a set flag
   assign jump = ~inpl & isJump & (flagSel == op.sense);

endmodule

// File: project.f
hw/mcpPkg.sv
hw/microJump.sv
hw/microClass.sv
hw/branchCond.sv
hw/mcpDecode.sv
testbench/mcpDecode_sva.sv
testbench/tbMcp.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -f project.f --top-module tbMcp -o simMcp \
   && ./obj_dir/simMcp | grep -F "** PASS **" \
   || exit 1

// File: testbench/mcpDecode_sva.sv
module mcpDecodeSva
   import mcpPkg::*;
(
   input logic       clk,
   input logic       rst,
   input logic       inValid,
   input logic       outValid,
   input decodeRsp_t rsp
);

   resetClears: assert property (@(posedge clk) rst |=> !outValid)
      else $error("outValid high in the cycle after reset");

   // Exactly one cycle of latency
   validFollows: assert property (@(posedge clk) !rst |=> outValid == $past(inValid))
      else $error("outValid does not follow inValid by one cycle");

   rspKnown: assert property (@(posedge clk) outValid |-> !$isunknown(rsp))
      else $error("rsp has unknown bits while outValid is high");

endmodule

bind mcpDecode mcpDecodeSva uSva
(
   .clk      (clk),
   .rst      (rst),
   .inValid  (inValid),
   .outValid (outValid),
   .rsp      (rsp)
);

// File: testbench/tbMcp.sv
module tbMcp
   import mcpPkg::*;
();

   logic        clk;
   logic        rst;
   logic        inValid;
   decodeReq_t  req;
   logic        outValid;
   decodeRsp_t  rsp;
   logic [31:0] lcgState;

   mcpDecode i_dut
   (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid),
      .req      (req),
      .outValid (outValid),
      .rsp      (rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("FAIL %s expected %0h actual %0h", name, expected, actual);
         $display("** FAIL **");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Polls after each edge until the response shows up
   task automatic waitValid(input string name);
      int cycles;
      cycles = 0;
      while (outValid !== 1'b1)
      begin
         if (cycles == 20)
         begin
            $display("Timeout in %s, the DUT gave no response within 20 cycles", name);
            $display("** FAIL **");
            $fatal(1, "Timeout");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   function automatic logic refJump(logic [7:0] op, logic [7:0] psw, logic icc, logic inpl);
      logic flag;
      if (inpl || op[7:4] != 4'h1)
         return 1'b0;
      case (op[3:1])
         3'd0: flag = psw[FlagZB];
         3'd1: flag = psw[FlagC8];
         3'd2: flag = icc;
         3'd3: flag = psw[FlagNB];
         3'd4: flag = psw[FlagZ];
         3'd5: flag = psw[FlagC];
         3'd6: flag = psw[FlagV];
         default: flag = psw[FlagN];
      endcase
      return flag == op[0];                 // Low bit is the sense
   endfunction

   // Pattern string reads MSB first, x is don't care
   function automatic logic matchPattern(logic [7:0] op, string pat);
      logic hit;
      hit = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         if (pat[i] != "x" && op[7-i] != (pat[i] == "1"))
            hit = 1'b0;
      end
      return hit;
   endfunction

   function automatic logic [DmiWidth-1:0] refClass(logic [7:0] op, logic inpl);
      logic [DmiWidth-1:0] lines;
      lines[0]  = matchPattern(op, "1010111x");
      lines[1]  = matchPattern(op, "10x001xx");
      lines[2]  = matchPattern(op, "110110xx");
      lines[3]  = matchPattern(op, "10101100");
      lines[4]  = matchPattern(op, "11111111");
      lines[5]  = matchPattern(op, "1111xxxx");
      lines[6]  = matchPattern(op, "x11111xx");
      lines[7]  = matchPattern(op, "1110001x");
      lines[8]  = matchPattern(op, "111011xx");
      lines[9]  = matchPattern(op, "01110101");
      lines[10] = matchPattern(op, "10xxxxxx");
      if (inpl)
      begin
         lines[2]   = 1'b0;
         lines[9:5] = '0;
      end
      return lines;
   endfunction

   function automatic logic refBranch(logic [15:0] dal, logic [7:0] psw);
      logic [4:0] code;
      logic       cond;
      logic       n;
      logic       z;
      logic       v;
      logic       c;
      code = {dal[15], dal[11:8]};
      n = psw[FlagN];
      z = psw[FlagZ];
      v = psw[FlagV];
      c = psw[FlagC];
      case (code[4:1])
         4'b1011: cond = c;
         4'b1010: cond = v;
         4'b1001: cond = z | c;
         4'b1000: cond = n;
         4'b0011: cond = z | (n ^ v);
         4'b0010: cond = n ^ v;
         4'b0001: cond = z;
         4'b0000: cond = 1'b1;
         default: cond = 1'b0;
      endcase
      return code[0] ? cond : ~cond;        // Even codes branch on the inverse
   endfunction

   function automatic decodeRsp_t refRsp(decodeReq_t r);
      decodeRsp_t e;
      e.microJump   = refJump(r.mir[15:8], r.psw, r.icc, r.inpl);
      e.branchTaken = refBranch(r.dal, r.psw);
      e.dmi         = refClass(r.mir[15:8], r.inpl);
      return e;
   endfunction

   function automatic decodeReq_t randomReq();
      decodeReq_t  r;
      logic [31:0] a;
      logic [31:0] b;
      a = nextRand();
      b = nextRand();
      r.mir  = a[31:16];
      r.dal  = b[31:16];
      r.psw  = b[15:8];
      r.icc  = a[14];
      r.inpl = a[15];
      return r;
   endfunction

   task automatic compareRsp(input string name, input decodeRsp_t e);
      check({name, " microJump"}, 32'(e.microJump), 32'(rsp.microJump));
      check({name, " branchTaken"}, 32'(e.branchTaken), 32'(rsp.branchTaken));
      check({name, " dmi"}, 32'(e.dmi), 32'(rsp.dmi));
   endtask

   // Drives one request, waits for its response and compares it
   task automatic applyOne(input string name, input decodeReq_t r);
      decodeRsp_t e;
      e = refRsp(r);
      req     = r;
      inValid = 1'b1;
      @(posedge clk);
      #1;
      inValid = 1'b0;
      waitValid(name);
      compareRsp(name, e);
   endtask

   task automatic testReset();
      decodeReq_t r;
      decodeRsp_t e;
      check("reset outValid", 32'd0, 32'(outValid));
      check("reset rsp", 32'd0, 32'(rsp));
      r = randomReq();
      e = refRsp(r);
      req     = r;
      inValid = 1'b1;
      @(posedge clk);
      #1;
      inValid = 1'b0;
      check("reset latency outValid", 32'd1, 32'(outValid));   // Exactly one cycle
      compareRsp("reset single", e);
      @(posedge clk);
      #1;
      check("reset outValid after single", 32'd0, 32'(outValid));
   endtask

   task automatic testJump();
      decodeReq_t r;
      for (int op = 16; op < 32; op++)
      begin
         for (int f = 0; f < 2; f++)
         begin
            r = randomReq();
            r.mir[15:8] = 8'(op);
            r.inpl      = 1'b0;
            r.psw       = f ? 8'hFF : 8'h00;   // Whichever flag is chosen reads f
            r.icc       = 1'(f);
            applyOne($sformatf("jump %02h flag %0d", op, f), r);
         end
         r = randomReq();
         r.mir[15:8] = 8'(op);
         r.inpl      = 1'b1;
         r.psw       = op[0] ? 8'hFF : 8'h00;  // Flag matches the sense
         r.icc       = op[0];
         applyOne($sformatf("jump %02h inpl", op), r);
      end
      r = randomReq();
      r.mir[15:8] = 8'h20;
      r.inpl      = 1'b0;
      r.psw       = 8'h00;                  // Would satisfy ZB with sense 0
      applyOne("jump non-jump 20", r);
      r.mir[15:8] = 8'h0F;
      r.psw       = 8'hFF;                  // Would satisfy N with sense 1
      applyOne("jump non-jump 0F", r);
   endtask

   task automatic testClass();
      logic [7:0] ops [8];
      decodeReq_t r;
      ops = '{8'hFF, 8'hAC, 8'hAE, 8'h75, 8'hE2, 8'hEC, 8'hD8, 8'hF3};
      for (int p = 0; p < 2; p++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            r = randomReq();
            r.mir[15:8] = ops[i];
            r.inpl      = 1'(p);
            applyOne($sformatf("class %02h inpl %0d", ops[i], p), r);
         end
      end
   endtask

   task automatic testBranch();
      logic [3:0] prefixes [10];
      decodeReq_t r;
      prefixes = '{4'b1011, 4'b1010, 4'b1001, 4'b1000, 4'b0011,
                   4'b0010, 4'b0001, 4'b0000, 4'b0100, 4'b1100};
      for (int p = 0; p < 10; p++)
      begin
         for (int s = 0; s < 2; s++)
         begin
            for (int n = 0; n < 16; n++)
            begin
               r = randomReq();
               r.dal[15]   = prefixes[p][3];
               r.dal[11:9] = prefixes[p][2:0];
               r.dal[8]    = 1'(s);
               r.psw[3:0]  = 4'(n);        // Every NZVC combination
               applyOne($sformatf("branch %04b.%0d nzvc %04b", prefixes[p], s, n), r);
            end
         end
      end
   endtask

   task automatic testStream();
      decodeReq_t r;
      decodeRsp_t e;
      for (int i = 0; i < 200; i++)
      begin
         r = randomReq();
         e = refRsp(r);
         req     = r;
         inValid = 1'b1;
         @(posedge clk);
         #1;
         check($sformatf("stream %0d outValid", i), 32'd1, 32'(outValid));
         compareRsp($sformatf("stream %0d", i), e);
      end
      inValid = 1'b0;
      @(posedge clk);
      #1;
      check("stream idle outValid", 32'd0, 32'(outValid));
   endtask

   initial
   begin
      rst      = 1'b1;
      inValid  = 1'b0;
      req      = '0;
      lcgState = 32'd20968;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      testReset();
      testJump();
      testClass();
      testBranch();
      testStream();
      $display("** PASS **");
      $finish;
   end

endmodule
